/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_processor -Mdir obj_dir
	./obj_dir/Vtb_processor > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* sim.f */
+incdir+tb
source/cpu_pkg.sv
source/fetch_stage.sv
source/operand_bypass.sv
source/alu.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/processor.sv
tb/processor_props.sv
tb/tb_processor.sv

/* source/alu.sv */
//////////////////////////////////////////////////
// Arithmetic and logic unit, six operations
//////////////////////////////////////////////////
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  word_t      a,
    input  word_t      b,
    input  alu_op_e    op,
    input  logic [4:0] shamt,
    output word_t      result
);

    always_comb begin
        case (op)
            ADD: begin
                result = a + b;
            end
            SUB: begin
                result = a - b;
            end
            AND: begin
                result = a & b;
            end
            OR: begin
                result = a | b;
            end
            SLL: begin
                result = a << shamt;
            end
            SRA: begin
                result = word_t'($signed(a) >>> shamt);   // Sign bit fills
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* source/cpu_pkg.sv */
//////////////////////////////////////////////////
// Shared types of the five-stage processor
// Instruction fields and pipeline register layouts
//////////////////////////////////////////////////
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [4:0] {
        R_TYPE = 5'b00000,
        J      = 5'b00001,
        BNE    = 5'b00010,
        JAL    = 5'b00011,
        JR     = 5'b00100,
        ADDI   = 5'b00101,
        BLT    = 5'b00110,
        SW     = 5'b00111,
        LW     = 5'b01000
    } opcode_e;

    typedef enum logic [4:0] {
        ADD = 5'b00000,
        SUB = 5'b00001,
        AND = 5'b00010,
        OR  = 5'b00011,
        SLL = 5'b00100,
        SRA = 5'b00101
    } alu_op_e;

    // Instruction field positions
    localparam int OPCODE_LSB  = 27;
    localparam int RD_LSB      = 22;
    localparam int RS_LSB      = 17;
    localparam int RT_LSB      = 12;
    localparam int SHAMT_LSB   = 7;
    localparam int ALU_OP_LSB  = 2;
    localparam int IMM_BITS    = 17;    // Sign extended
    localparam int TARGET_BITS = 27;    // Zero extended

    localparam reg_idx_t LINK_REG = 5'd31;  // jal destination

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t insn;
    } fd_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        alu_op_e  alu_op;
        logic [4:0] shamt;
        logic     use_imm;
        logic     writes_rd;
        logic     is_load;
        logic     is_store;
        word_t    a_value;
        word_t    b_value;
        word_t    imm;
    } dx_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     writes_rd;
        logic     is_load;
        logic     is_store;
        word_t    result;
        word_t    store_data;
    } xm_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     writes_rd;
        word_t    wdata;
    } mw_t;

    // Result on its way back to the decode stage
    typedef struct packed {
        logic     hit_ok;   // Valid write to a nonzero rd
        reg_idx_t rd;
        word_t    data;
        logic     is_load;
    } fwd_t;

endpackage

/* source/decode_stage.sv */
//////////////////////////////////////////////////
// Decode stage, register read and branch resolution
//////////////////////////////////////////////////
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  fd_t      fd,
    output reg_idx_t ctrl_read_reg_a,
    output reg_idx_t ctrl_read_reg_b,
    input  word_t    data_read_reg_a,
    input  word_t    data_read_reg_b,
    input  fwd_t     ex_fwd,
    input  fwd_t     mem_fwd,
    input  fwd_t     wb_fwd,
    output logic     stall,
    output logic     redirect,
    output word_t    redirect_pc,
    output dx_t      dx
);

    opcode_e    opcode;
    reg_idx_t   rd;
    reg_idx_t   rs;
    reg_idx_t   rt;
    word_t      imm;
    word_t      jump_target;
    word_t      pc_plus_1;
    word_t      a_value;
    word_t      b_value;
    logic       is_rtype, is_j, is_bne, is_jal, is_jr;
    logic       is_addi, is_blt, is_sw, is_lw;
    logic       reads_a;
    logic       reads_b;
    logic       branch_taken;
    dx_t        dx_next;
    dx_t        dx_body;
    logic       dx_valid;

    assign opcode      = opcode_e'(fd.insn[OPCODE_LSB +: 5]);
    assign rd          = fd.insn[RD_LSB +: 5];
    assign rs          = fd.insn[RS_LSB +: 5];
    assign rt          = fd.insn[RT_LSB +: 5];
    assign imm         = {{(32 - IMM_BITS){fd.insn[IMM_BITS - 1]}}, fd.insn[IMM_BITS - 1:0]};
    assign jump_target = {{(32 - TARGET_BITS){1'b0}}, fd.insn[TARGET_BITS - 1:0]};
    assign pc_plus_1   = fd.pc + 32'd1;

    assign is_rtype = (opcode == R_TYPE);
    assign is_j     = (opcode == J);
    assign is_bne   = (opcode == BNE);
    assign is_jal   = (opcode == JAL);
    assign is_jr    = (opcode == JR);
    assign is_addi  = (opcode == ADDI);
    assign is_blt   = (opcode == BLT);
    assign is_sw    = (opcode == SW);
    assign is_lw    = (opcode == LW);

    // Branches compare rd against rs, sw stores rd
    assign ctrl_read_reg_a = (is_bne | is_blt | is_jr) ? rd : rs;
    assign ctrl_read_reg_b = (is_bne | is_blt) ? rs : (is_sw ? rd : rt);

    assign reads_a = fd.valid & (is_rtype | is_addi | is_lw | is_sw | is_bne | is_blt | is_jr);
    assign reads_b = fd.valid & (is_rtype | is_bne | is_blt | is_sw);

    operand_bypass bypass_i (
        .ctrl_read_reg_a (ctrl_read_reg_a),
        .ctrl_read_reg_b (ctrl_read_reg_b),
        .reads_a         (reads_a),
        .reads_b         (reads_b),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .ex_fwd          (ex_fwd),
        .mem_fwd         (mem_fwd),
        .wb_fwd          (wb_fwd),
        .a_value         (a_value),
        .b_value         (b_value),
        .stall           (stall)
    );

    assign branch_taken = (is_bne & (a_value != b_value)) |
                          (is_blt & ($signed(a_value) < $signed(b_value)));

    assign redirect = fd.valid & ~stall & (branch_taken | is_j | is_jal | is_jr);

    always_comb begin
        if (is_jr) begin
            redirect_pc = a_value;
        end else if (is_j | is_jal) begin
            redirect_pc = jump_target;
        end else begin
            redirect_pc = pc_plus_1 + imm;  // Taken branch
        end
    end

    always_comb begin
        dx_next.valid     = fd.valid & ~stall;  // Bubble under stall
        dx_next.rd        = is_jal ? LINK_REG : rd;
        dx_next.alu_op    = is_rtype ? alu_op_e'(fd.insn[ALU_OP_LSB +: 5]) : ADD;
        dx_next.shamt     = fd.insn[SHAMT_LSB +: 5];
        dx_next.use_imm   = is_addi | is_lw | is_sw;
        dx_next.writes_rd = is_rtype | is_addi | is_lw | is_jal;
        dx_next.is_load   = is_lw;
        dx_next.is_store  = is_sw;
        // Link value rides through the ALU as PC+1 plus zero
        dx_next.a_value   = is_jal ? pc_plus_1 : a_value;
        dx_next.b_value   = is_jal ? '0 : b_value;
        dx_next.imm       = imm;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dx_valid <= 1'b0;
        end else begin
            dx_valid <= dx_next.valid;
        end
    end

    always_ff @(posedge clock) begin
        dx_body <= dx_next;
    end

    always_comb begin
        dx       = dx_body;
        dx.valid = dx_valid;
    end

endmodule

/* source/execute_stage.sv */
//////////////////////////////////////////////////
// Execute stage and execute/memory register
//////////////////////////////////////////////////
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic clock,
    input  logic rst_n,
    input  dx_t  dx,
    output fwd_t ex_fwd,
    output xm_t  xm
);

    word_t operand_b;
    word_t alu_result;
    xm_t   xm_next;
    xm_t   xm_body;
    logic  xm_valid;

    assign operand_b = dx.use_imm ? dx.imm : dx.b_value;   // addi, lw, sw

    alu alu_i (
        .a      (dx.a_value),
        .b      (operand_b),
        .op     (dx.alu_op),
        .shamt  (dx.shamt),
        .result (alu_result)
    );

    // For a load this carries the address, so decode stalls on it
    assign ex_fwd = '{
        hit_ok:  dx.valid & dx.writes_rd & (dx.rd != '0),
        rd:      dx.rd,
        data:    alu_result,
        is_load: dx.is_load
    };

    assign xm_next = '{
        valid:      dx.valid,
        rd:         dx.rd,
        writes_rd:  dx.writes_rd,
        is_load:    dx.is_load,
        is_store:   dx.is_store,
        result:     alu_result,
        store_data: dx.b_value
    };

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            xm_valid <= 1'b0;
        end else begin
            xm_valid <= xm_next.valid;
        end
    end

    always_ff @(posedge clock) begin
        xm_body <= xm_next;
    end

    always_comb begin
        xm       = xm_body;
        xm.valid = xm_valid;
    end

endmodule

/* source/fetch_stage.sv */
//////////////////////////////////////////////////
// Fetch stage with PC and fetch/decode register
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    output word_t address_imem,
    input  word_t q_imem,
    output fd_t   fd
);

    word_t pc;
    logic  fd_valid;
    word_t fd_pc;
    word_t fd_insn;

    assign address_imem = pc;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            fd_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= redirect_pc;
            fd_valid <= 1'b0;       // Kill the wrong-path fetch
        end else if (!stall) begin
            pc       <= pc + 32'd1;
            fd_valid <= 1'b1;
        end
    end

    // Word and its PC, held during a load-use stall
    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc   <= pc;
            fd_insn <= q_imem;
        end
    end

    assign fd = '{valid: fd_valid, pc: fd_pc, insn: fd_insn};

endmodule

/* source/mem_wb_stage.sv */
//////////////////////////////////////////////////
// Memory access and register-file writeback
//////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_wb_stage import cpu_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  xm_t      xm,
    output word_t    address_dmem,
    output word_t    data,
    output logic     wren,
    input  word_t    q_dmem,
    output fwd_t     mem_fwd,
    output fwd_t     wb_fwd,
    output logic     ctrl_write_enable,
    output reg_idx_t ctrl_write_reg,
    output word_t    data_write_reg
);

    mw_t  mw_next;
    mw_t  mw_body;
    mw_t  mw;
    logic mw_valid;

    assign address_dmem = xm.result;
    assign data         = xm.store_data;
    assign wren         = xm.valid & xm.is_store;     // Strobe for this edge

    // Load data is ready here since the memory read is combinational
    assign mem_fwd = '{
        hit_ok:  xm.valid & xm.writes_rd & (xm.rd != '0),
        rd:      xm.rd,
        data:    xm.is_load ? q_dmem : xm.result,
        is_load: xm.is_load
    };

    assign mw_next = '{valid: xm.valid, rd: xm.rd, writes_rd: xm.writes_rd, wdata: mem_fwd.data};

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mw_valid <= 1'b0;
        end else begin
            mw_valid <= mw_next.valid;
        end
    end

    always_ff @(posedge clock) begin
        mw_body <= mw_next;
    end

    always_comb begin
        mw       = mw_body;
        mw.valid = mw_valid;
    end

    assign wb_fwd = '{
        hit_ok:  mw.valid & mw.writes_rd & (mw.rd != '0),
        rd:      mw.rd,
        data:    mw.wdata,
        is_load: 1'b0
    };

    // Written at the end of this cycle
    assign ctrl_write_enable = wb_fwd.hit_ok;
    assign ctrl_write_reg    = mw.rd;
    assign data_write_reg    = mw.wdata;

endmodule

/* source/operand_bypass.sv */
//////////////////////////////////////////////////
// Operand bypass and load-use stall detection
//////////////////////////////////////////////////
`timescale 1ns/1ps

module operand_bypass import cpu_pkg::*; (
    input  reg_idx_t ctrl_read_reg_a,
    input  reg_idx_t ctrl_read_reg_b,
    input  logic     reads_a,
    input  logic     reads_b,
    input  word_t    data_read_reg_a,
    input  word_t    data_read_reg_b,
    input  fwd_t     ex_fwd,
    input  fwd_t     mem_fwd,
    input  fwd_t     wb_fwd,
    output word_t    a_value,
    output word_t    b_value,
    output logic     stall
);

    function automatic logic hits(input fwd_t f, input reg_idx_t idx);
        return f.hit_ok && (f.rd == idx);
    endfunction

    // Youngest producer wins
    function automatic word_t pick(
        input reg_idx_t idx,
        input word_t    rf_value,
        input fwd_t     ex,
        input fwd_t     mem,
        input fwd_t     wb
    );
        if (hits(ex, idx)) begin
            return ex.data;
        end else if (hits(mem, idx)) begin
            return mem.data;
        end else if (hits(wb, idx)) begin
            return wb.data;
        end
        return rf_value;
    endfunction

    assign a_value = pick(ctrl_read_reg_a, data_read_reg_a, ex_fwd, mem_fwd, wb_fwd);
    assign b_value = pick(ctrl_read_reg_b, data_read_reg_b, ex_fwd, mem_fwd, wb_fwd);

    // Load data is not there until the memory stage
    assign stall = ex_fwd.is_load &
                   ((reads_a & hits(ex_fwd, ctrl_read_reg_a)) |
                    (reads_b & hits(ex_fwd, ctrl_read_reg_b)));

endmodule

/* source/processor.sv */
//////////////////////////////////////////////////
// Five-stage pipelined processor top level
//////////////////////////////////////////////////
`timescale 1ns/1ps

module processor import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic     clock,
    input  logic     rst_n,
    // Instruction memory
    output word_t    address_imem,
    input  word_t    q_imem,
    // Data memory
    output word_t    address_dmem,
    output word_t    data,
    output logic     wren,
    input  word_t    q_dmem,
    // Register file
    output logic     ctrl_write_enable,
    output reg_idx_t ctrl_write_reg,
    output reg_idx_t ctrl_read_reg_a,
    output reg_idx_t ctrl_read_reg_b,
    output word_t    data_write_reg,
    input  word_t    data_read_reg_a,
    input  word_t    data_read_reg_b
);

    fd_t   fd;
    dx_t   dx;
    xm_t   xm;
    fwd_t  ex_fwd;
    fwd_t  mem_fwd;
    fwd_t  wb_fwd;
    logic  stall;
    logic  redirect;
    word_t redirect_pc;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .fd           (fd)
    );

    decode_stage decode_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .fd              (fd),
        .ctrl_read_reg_a (ctrl_read_reg_a),
        .ctrl_read_reg_b (ctrl_read_reg_b),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .ex_fwd          (ex_fwd),
        .mem_fwd         (mem_fwd),
        .wb_fwd          (wb_fwd),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .dx              (dx)
    );

    execute_stage execute_i (
        .clock  (clock),
        .rst_n  (rst_n),
        .dx     (dx),
        .ex_fwd (ex_fwd),
        .xm     (xm)
    );

    mem_wb_stage mem_wb_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .xm                (xm),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .mem_fwd           (mem_fwd),
        .wb_fwd            (wb_fwd),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .data_write_reg    (data_write_reg)
    );

endmodule

/* tb/processor_props.sv */
//////////////////////////////////////////////////
// Port properties of the processor, bound in
//////////////////////////////////////////////////
`timescale 1ns/1ps

module processor_props import cpu_pkg::*; (
    input logic     clock,
    input logic     rst_n,
    input logic     wren,
    input logic     ctrl_write_enable,
    input reg_idx_t ctrl_write_reg
);

    // All valid bits are clear in reset
    quiet_in_reset: assert property (
        @(posedge clock) !rst_n |-> (!wren && !ctrl_write_enable)
    ) else $error("Write strobe active during reset");

    no_r0_write: assert property (
        @(posedge clock) disable iff (!rst_n) ctrl_write_enable |-> (ctrl_write_reg != '0)
    ) else $error("Register file write to r0");

    wren_known: assert property (
        @(posedge clock) !$isunknown(wren)
    ) else $error("Data memory write strobe is unknown");

endmodule

bind processor processor_props props_i (
    .clock             (clock),
    .rst_n             (rst_n),
    .wren              (wren),
    .ctrl_write_enable (ctrl_write_enable),
    .ctrl_write_reg    (ctrl_write_reg)
);

/* tb/program_gen.svh */
//////////////////////////////////////////////////
// Random program builder and instruction-level model
//////////////////////////////////////////////////
`ifndef PROGRAM_GEN_SVH
`define PROGRAM_GEN_SVH

typedef enum int {
    K_ALU, K_ADDI, K_LW, K_SW, K_BNE, K_BLT, K_J, K_JAL, K_JR_SET, K_JR
} slot_e;

function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

function automatic word_t enc_r(input alu_op_e op, input reg_idx_t rd, input reg_idx_t rs,
                                input reg_idx_t rt, input logic [4:0] shamt);
    return {R_TYPE, rd, rs, rt, shamt, op, 2'b00};
endfunction

function automatic word_t enc_i(input opcode_e op, input reg_idx_t rd, input reg_idx_t rs,
                                input logic [16:0] imm);
    return {op, rd, rs, imm};
endfunction

function automatic word_t enc_j(input opcode_e op, input logic [26:0] target);
    return {op, target};
endfunction

task automatic build_program();
    slot_e    kind [0:PROG_LEN-1];
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t jr_reg;
    int       i;
    int       r;
    int       tgt;
    reg_init[0] = '0;
    for (i = 1; i < 32; i++) begin
        reg_init[i] = $random(seed);
    end
    i = 0;
    while (i < PROG_LEN - 1) begin
        r = rand_below(12);
        kind[i] = (r < 4) ? K_ALU : slot_e'(r - 3);
        if (kind[i] == K_JR_SET && i == PROG_LEN - 2) begin
            kind[i] = K_ALU;        // No room left for its jr
        end else if (kind[i] == K_JR_SET) begin
            kind[i + 1] = K_JR;
            i++;
        end
        i++;
    end
    kind[PROG_LEN - 1] = K_J;       // Final self-jump
    jr_reg = 5'd1;
    for (i = 0; i < PROG_LEN; i++) begin
        rd  = reg_idx_t'(1 + rand_below(7));
        rs  = reg_idx_t'(rand_below(8));
        rt  = reg_idx_t'(rand_below(8));
        tgt = i + 2 + rand_below(4);
        if (tgt > PROG_LEN - 1) begin
            tgt = PROG_LEN - 1;
        end
        // Never land on a jr without its addi
        if (kind[tgt] == K_JR) begin
            tgt++;
        end
        case (kind[i])
            K_ALU:    imem[i] = enc_r(alu_op_e'(rand_below(6)), rd, rs, rt, 5'(rand_below(32)));
            K_ADDI:   imem[i] = enc_i(ADDI, rd, rs, 17'($random(seed)));
            K_LW:     imem[i] = enc_i(LW, rd, 5'd0, 17'(rand_below(16)));
            K_SW:     imem[i] = enc_i(SW, rd, 5'd0, 17'(rand_below(16)));
            K_BNE:    imem[i] = enc_i(BNE, rt, rs, 17'(tgt - i - 1));
            K_BLT:    imem[i] = enc_i(BLT, rt, rs, 17'(tgt - i - 1));
            K_J:      imem[i] = enc_j(J, 27'(tgt));
            K_JAL:    imem[i] = enc_j(JAL, 27'(tgt));
            K_JR_SET: begin
                jr_reg  = rd;
                imem[i] = enc_i(ADDI, rd, 5'd0, 17'(tgt));
            end
            default:  imem[i] = enc_i(JR, jr_reg, 5'd0, 17'd0);
        endcase
    end
endtask

task automatic run_model();
    word_t      mregs [0:31];
    word_t      mdmem [0:63];
    word_t      insn;
    word_t      imm;
    word_t      addr;
    word_t      wval;
    logic       wen;
    reg_idx_t   rd;
    reg_idx_t   rs;
    reg_idx_t   rt;
    logic [4:0] sh;
    int         pc;
    int         next_pc;
    int         step;
    mregs = reg_init;
    mdmem = dmem_init;
    pc    = 0;
    for (step = 0; step < PROG_LEN && pc != PROG_LEN - 1; step++) begin
        insn    = imem[pc];
        rd      = insn[26:22];
        rs      = insn[21:17];
        rt      = insn[16:12];
        sh      = insn[11:7];
        imm     = {{15{insn[16]}}, insn[16:0]};
        addr    = mregs[rs] + imm;
        next_pc = pc + 1;
        wen     = 1'b0;
        wval    = '0;
        case (opcode_e'(insn[31:27]))
            R_TYPE: begin
                wen = 1'b1;
                case (alu_op_e'(insn[6:2]))
                    ADD:     wval = mregs[rs] + mregs[rt];
                    SUB:     wval = mregs[rs] - mregs[rt];
                    AND:     wval = mregs[rs] & mregs[rt];
                    OR:      wval = mregs[rs] | mregs[rt];
                    SLL:     wval = mregs[rs] << sh;
                    default: wval = word_t'($signed(mregs[rs]) >>> sh);
                endcase
            end
            ADDI: begin
                wen  = 1'b1;
                wval = addr;
            end
            LW: begin
                wen  = 1'b1;
                wval = mdmem[addr[5:0]];
            end
            SW: begin
                mdmem[addr[5:0]] = mregs[rd];
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(mregs[rd]);
            end
            BNE: if (mregs[rd] != mregs[rs]) next_pc = pc + 1 + int'(imm);
            BLT: if ($signed(mregs[rd]) < $signed(mregs[rs])) next_pc = pc + 1 + int'(imm);
            J:   next_pc = int'(insn[26:0]);
            JAL: begin
                wen     = 1'b1;
                rd      = 5'd31;            // Link register gets PC+1
                wval    = word_t'(pc + 1);
                next_pc = int'(insn[26:0]);
            end
            default: next_pc = int'(mregs[rd]);     // jr
        endcase
        if (wen && rd != '0) begin
            mregs[rd] = wval;
            exp_wr_reg.push_back(rd);
            exp_wr_data.push_back(wval);
        end
        pc = next_pc;
    end
endtask

`endif

/* tb/tb_processor.sv */
//////////////////////////////////////////////////
// Testbench for the pipelined processor
// Random program run against an instruction-level model
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_processor import cpu_pkg::*;;

    localparam int PROG_LEN       = 64;
    localparam int TIMEOUT_CYCLES = 400;    // 64 instructions at 3 cycles, drain and margin

    logic     clock;
    logic     rst_n;
    word_t    address_imem;
    word_t    q_imem;
    word_t    address_dmem;
    word_t    data;
    logic     wren;
    word_t    q_dmem;
    logic     ctrl_write_enable;
    reg_idx_t ctrl_write_reg;
    reg_idx_t ctrl_read_reg_a;
    reg_idx_t ctrl_read_reg_b;
    word_t    data_write_reg;
    word_t    data_read_reg_a;
    word_t    data_read_reg_b;

    word_t    imem [0:PROG_LEN-1];
    word_t    dmem [0:63];
    word_t    dmem_init [0:63];
    word_t    regs [0:31];
    word_t    reg_init [0:31];
    reg_idx_t exp_wr_reg [$];
    word_t    exp_wr_data [$];
    word_t    exp_st_addr [$];
    word_t    exp_st_data [$];
    int       seed;
    int       cycle_count;
    int       writes_seen;
    int       stores_seen;
    int       wr_expected;
    int       st_expected;
    string    test_name = "random_program";

    `include "program_gen.svh"

    processor #(
        .RESET_PC (32'd0)
    ) processor_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .address_imem      (address_imem),
        .q_imem            (q_imem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .ctrl_read_reg_a   (ctrl_read_reg_a),
        .ctrl_read_reg_b   (ctrl_read_reg_b),
        .data_write_reg    (data_write_reg),
        .data_read_reg_a   (data_read_reg_a),
        .data_read_reg_b   (data_read_reg_b)
    );

    // Combinational reads of the memory and register-file models
    assign q_imem          = imem[address_imem[5:0]];
    assign q_dmem          = dmem[address_dmem[5:0]];
    assign data_read_reg_a = regs[ctrl_read_reg_a];
    assign data_read_reg_b = regs[ctrl_read_reg_b];

    always @(posedge clock) begin
        if (!rst_n) begin
            regs <= reg_init;       // Contents loaded while in reset
            dmem <= dmem_init;
        end else begin
            if (ctrl_write_enable && ctrl_write_reg != '0) begin
                regs[ctrl_write_reg] <= data_write_reg;
            end
            if (wren) begin
                dmem[address_dmem[5:0]] <= data;
            end
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_reg_write(input reg_idx_t idx, input word_t value);
        reg_idx_t exp_idx;
        word_t    exp_value;
        if (exp_wr_reg.size() == 0) begin
            report_failure($sformatf("Register write to r%0d that the model never makes", idx));
        end else begin
            exp_idx   = exp_wr_reg.pop_front();
            exp_value = exp_wr_data.pop_front();
            writes_seen++;
            if (idx !== exp_idx || value !== exp_value) begin
                report_failure($sformatf(
                    "MISMATCH %s write %0d: expected r%0d=%h, actual r%0d=%h",
                    test_name, writes_seen, exp_idx, exp_value, idx, value));
            end
        end
    endtask

    task automatic check_store(input word_t addr, input word_t value);
        word_t exp_addr;
        word_t exp_value;
        if (exp_st_addr.size() == 0) begin
            report_failure($sformatf("Store to address %h that the model never makes", addr));
        end else begin
            exp_addr  = exp_st_addr.pop_front();
            exp_value = exp_st_data.pop_front();
            stores_seen++;
            if (addr !== exp_addr || value !== exp_value) begin
                report_failure($sformatf(
                    "MISMATCH %s store %0d: expected [%h]=%h, actual [%h]=%h",
                    test_name, stores_seen, exp_addr, exp_value, addr, value));
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Write and store events, sampled mid-cycle
    always @(negedge clock) begin
        if (rst_n && ctrl_write_enable) begin
            check_reg_write(ctrl_write_reg, data_write_reg);
        end
        if (rst_n && wren) begin
            check_store(address_dmem, data);
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: run did not finish in %0d cycles", cycle_count));
        end
    end

    initial begin
        rst_n       = 1'b0;
        seed        = 32'h79c3;
        cycle_count = 0;
        writes_seen = 0;
        stores_seen = 0;
        for (int i = 0; i < 64; i++) begin
            dmem_init[i] = 32'hd00d_0000 ^ (word_t'(i) * 32'h9e37_79b9);
        end
        build_program();
        run_model();
        wr_expected = exp_wr_reg.size();
        st_expected = exp_st_addr.size();
        repeat (2) @(negedge clock);
        rst_n = 1'b1;
        // Run until fetch reaches the final self-jump
        while (address_imem != word_t'(PROG_LEN - 1)) begin
            @(negedge clock);
        end
        repeat (20) @(posedge clock);   // Drain, nothing more may appear
        if (writes_seen != wr_expected || stores_seen != st_expected) begin
            report_failure($sformatf("Event count off: %0d/%0d writes, %0d/%0d stores",
                                     writes_seen, wr_expected, stores_seen, st_expected));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule
